// ==== design/ttt_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// tic-tac-toe sizing constants
// board geometry and position width
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TTT_MACROS_SVH
`define TTT_MACROS_SVH

// three by three board
`define TTT_CELLS 9

// position inputs are four bits wide, so codes 9..15 reach the
// arbiter and get rejected there as out of range
`define TTT_POS_W 4

// rows, columns and both diagonals
`define TTT_LINES 8

`endif

// ==== design/ttt_board_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// board types: marks, board bus, positions
// ~~~~~~~~~~~~~~~~~~~~
`include "ttt_macros.svh"

package ttt_board_pkg;

    // encoding kept from the led outputs of the old game
    typedef enum logic [1:0]
    {
        MARK_EMPTY    = 2'b00,
        MARK_PLAYER   = 2'b01, // player
        MARK_COMPUTER = 2'b10  // computer
    } mark_t;

    // cell 0 top-left, row by row, so cell 8 is bottom-right
    typedef mark_t [`TTT_CELLS-1:0] board_t;

    // raw position from a button bank, may exceed the board
    typedef logic [`TTT_POS_W-1:0] pos_t;

endpackage

// ==== design/ttt_turn_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// turn controller types
// ~~~~~~~~~~~~~~~~~~~~

package ttt_turn_pkg;

    // turn fsm states
    typedef enum logic [1:0]
    {
        TURN_IDLE     = 2'b00, // waiting for play
        TURN_PLAYER   = 2'b01, // player move under test
        TURN_COMPUTER = 2'b10, // waiting for pc
        TURN_DONE     = 2'b11  // line or full board, held until reset
    } turn_state_t;

    // who owns the board write port this cycle
    typedef enum logic
    {
        SRC_PLAYER   = 1'b0,
        SRC_COMPUTER = 1'b1
    } move_src_t;

endpackage

// ==== design/board_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// board store
// nine mark registers behind one write port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ttt_macros.svh"

module board_store
    import ttt_board_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   write_en,   // from the arbiter only
    input  pos_t   write_pos,
    input  mark_t  write_mark,
    output board_t board
);

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `TTT_CELLS; i++)
            begin
                board[i] <= MARK_EMPTY; // fresh game
            end
        end
        else if (write_en)
        begin
            // compare per cell, an out-of-range code hits nothing
            for (int i = 0; i < `TTT_CELLS; i++)
            begin
                if (write_pos == pos_t'(i))
                    board[i] <= write_mark;
            end
        end
    end

    // the arbiter must have filtered every write against this same board
    a_write_in_range: assert property (
        @(posedge clock) disable iff (reset)
        write_en |-> write_pos < pos_t'(`TTT_CELLS))
        else $error("board write to position %0d off the board", write_pos);

    a_write_free_cell: assert property (
        @(posedge clock) disable iff (reset)
        write_en && write_pos < pos_t'(`TTT_CELLS) |-> board[write_pos] == MARK_EMPTY)
        else $error("board write over occupied cell %0d", write_pos);

    a_write_has_mark: assert property (
        @(posedge clock) disable iff (reset)
        write_en |-> write_mark != MARK_EMPTY)
        else $error("board write carries an empty mark");

endmodule

// ==== design/line_judge.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// line judge
// completed line, its owner and full board
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ttt_macros.svh"

module line_judge
    import ttt_board_pkg::*;
(
    input  board_t board,
    output logic   line_done,
    output mark_t  line_owner,  // MARK_EMPTY while no line
    output logic   board_full
);

    // cell triples of every winning line
    localparam int LINE_CELL [`TTT_LINES][3] = '{
        '{0, 1, 2}, '{3, 4, 5}, '{6, 7, 8},  // rows
        '{0, 3, 6}, '{1, 4, 7}, '{2, 5, 8},  // columns
        '{0, 4, 8}, '{2, 4, 6}               // diagonals
    };

    logic [`TTT_LINES-1:0] player_line;   // per line, all three player
    logic [`TTT_LINES-1:0] computer_line; // per line, all three computer

    // true when all three cells of line l hold mark m
    function automatic logic line_is(board_t b, int l, mark_t m);
        return b[LINE_CELL[l][0]] == m
            && b[LINE_CELL[l][1]] == m
            && b[LINE_CELL[l][2]] == m;
    endfunction

    always_comb
    begin
        for (int l = 0; l < `TTT_LINES; l++)
        begin
            player_line[l]   = line_is(board, l, MARK_PLAYER);
            computer_line[l] = line_is(board, l, MARK_COMPUTER);
        end
    end

    assign line_done = (|player_line) | (|computer_line);

    always_comb
    begin
        if (|player_line)
            line_owner = MARK_PLAYER;
        else if (|computer_line)
            line_owner = MARK_COMPUTER;
        else
            line_owner = MARK_EMPTY;
    end

    always_comb
    begin
        board_full = 1'b1;
        for (int i = 0; i < `TTT_CELLS; i++)
        begin
            if (board[i] == MARK_EMPTY)
                board_full = 1'b0; // any hole keeps play going
        end
    end

    // the arbiter stops the game on the first line, so two owners never coexist
    always_comb
    begin
        assert (!((|player_line) && (|computer_line)))
            else $error("lines complete for both marks, board %h", board);
    end

endmodule

// ==== design/turn_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// turn arbiter
// turn fsm, legality check and board write grant
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ttt_macros.svh"

module turn_arbiter
    import ttt_board_pkg::*;
    import ttt_turn_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   play,              // one-cycle player strobe
    input  logic   pc,                // one-cycle computer strobe
    input  pos_t   player_position,
    input  pos_t   computer_position,
    input  board_t board,             // board after the last write
    input  logic   line_done,         // zero-latency line_judge result
    input  logic   board_full,
    output logic   write_en,
    output pos_t   write_pos,
    output mark_t  write_mark,
    output logic   illegal_move,      // one-cycle pulse
    output logic   game_over
);

    turn_state_t state;
    turn_state_t state_next;
    pos_t        player_pos_q; // player move held for the decide cycle
    move_src_t   grant;
    pos_t        req_pos;
    logic        req_valid;    // a move is presented for decision now
    logic        req_legal;
    logic        game_end;

    // legal when in range and empty
    function automatic logic cell_free(board_t b, pos_t p);
        logic free;
        free = 1'b0;
        for (int i = 0; i < `TTT_CELLS; i++)
        begin
            if (p == pos_t'(i) && b[i] == MARK_EMPTY)
                free = 1'b1;
        end
        return free;
    endfunction

    assign game_end = line_done | board_full;

    // port owner follows the turn
    assign grant     = (state == TURN_COMPUTER) ? SRC_COMPUTER : SRC_PLAYER;
    assign req_pos   = (grant == SRC_COMPUTER) ? computer_position : player_pos_q;
    assign req_legal = cell_free(board, req_pos);

    always_comb
    begin
        case (state)
            TURN_PLAYER:   req_valid = 1'b1;             // decide the latched move now
            TURN_COMPUTER: req_valid = pc & ~game_end;   // pc dropped once the game is over
            default:       req_valid = 1'b0;
        endcase
    end

    assign write_en     = req_valid & req_legal;
    assign illegal_move = req_valid & ~req_legal;
    assign write_pos    = req_pos;
    assign write_mark   = (grant == SRC_COMPUTER) ? MARK_COMPUTER : MARK_PLAYER;
    assign game_over    = (state == TURN_DONE);

    always_comb
    begin
        state_next = state;
        case (state)
            TURN_IDLE:
            begin
                // a finished game wins over a fresh play strobe
                if (game_end)
                    state_next = TURN_DONE;
                else if (play)
                    state_next = TURN_PLAYER;
            end
            TURN_PLAYER:
            begin
                if (req_legal)
                    state_next = TURN_COMPUTER;
                else
                    state_next = TURN_IDLE; // player tries again
            end
            TURN_COMPUTER:
            begin
                if (game_end)
                    state_next = TURN_DONE; // player's move ended it
                else if (pc && req_legal)
                    state_next = TURN_IDLE;
                // illegal pc keeps the computer's turn
            end
            TURN_DONE:
            begin
                state_next = TURN_DONE; // only reset leaves
            end
            default:
            begin
                state_next = TURN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            state <= TURN_IDLE;
        else
            state <= state_next;
    end

    // position capture on the accepted play edge
    always_ff @(posedge clock)
    begin
        if (state == TURN_IDLE && play && !game_end)
            player_pos_q <= player_position;
    end

    // an accepted write always hands the turn on
    a_write_ends_turn: assert property (
        @(posedge clock) disable iff (reset)
        write_en |=> state != $past(state))
        else $error("board write did not end the turn, state %s", state.name());

    // a rejected move never finishes the game
    a_illegal_not_final: assert property (
        @(posedge clock) disable iff (reset)
        illegal_move |=> !game_over)
        else $error("illegal move followed by game over");

endmodule

// ==== design/tic_tac_toe_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tic-tac-toe top
// arbiter, board store and line judge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ttt_macros.svh"

module tic_tac_toe_top
    import ttt_board_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   play,               // player button
    input  logic   pc,                 // computer button
    input  pos_t   player_position,
    input  pos_t   computer_position,
    output board_t board,              // cell leds
    output mark_t  winner,
    output logic   game_over,
    output logic   illegal_move
);

    logic  write_en;
    pos_t  write_pos;
    mark_t write_mark;
    logic  line_done;
    logic  board_full;

    // single writer for both move sources
    turn_arbiter i_turn_arbiter (
        .clock             (clock),
        .reset             (reset),
        .play              (play),
        .pc                (pc),
        .player_position   (player_position),
        .computer_position (computer_position),
        .board             (board),
        .line_done         (line_done),
        .board_full        (board_full),
        .write_en          (write_en),
        .write_pos         (write_pos),
        .write_mark        (write_mark),
        .illegal_move      (illegal_move),
        .game_over         (game_over)
    );

    board_store i_board_store (
        .clock      (clock),
        .reset      (reset),
        .write_en   (write_en),
        .write_pos  (write_pos),
        .write_mark (write_mark),
        .board      (board)
    );

    line_judge i_line_judge (
        .board      (board),
        .line_done  (line_done),
        .line_owner (winner),     // owner is the winner
        .board_full (board_full)
    );

endmodule

// ==== bench/tb_tic_tac_toe.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tic-tac-toe testbench
// random games checked against a board model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ttt_macros.svh"

module tb_tic_tac_toe
    import ttt_board_pkg::*;
    import ttt_turn_pkg::*;
();

    localparam int CLOCK_PERIOD    = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_GAMES       = 40;
    localparam int MAX_MOVES       = 64;  // move attempts per game, retries included
    localparam int RANDOM_TRIES    = 6;   // then fall back to the first free cell
    localparam int SEED            = 30907;
    localparam int WATCHDOG_CYCLES = (NUM_GAMES + 2) * MAX_MOVES * 10;

    logic   clock;
    logic   reset;
    logic   play;
    logic   pc;
    pos_t   player_position;
    pos_t   computer_position;
    board_t board;
    mark_t  winner;
    logic   game_over;
    logic   illegal_move;

    board_t model_board; // expected board after the last accepted move
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    int     draw_count  = 0;

    tic_tac_toe_top i_tic_tac_toe_top (
        .clock             (clock),
        .reset             (reset),
        .play              (play),
        .pc                (pc),
        .player_position   (player_position),
        .computer_position (computer_position),
        .board             (board),
        .winner            (winner),
        .game_over         (game_over),
        .illegal_move      (illegal_move)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // run limit scaled by games and moves
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    task automatic check_board(input board_t got, input board_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("MISMATCH board expected %h got %h", exp, got);
            error_count++;
        end
    endtask

    task automatic check_winner(input mark_t got, input mark_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("MISMATCH winner expected %h got %h", exp, got);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        check_count++;
        if (got !== exp)
        begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            error_count++;
        end
    endtask

    // three cells share one non-empty mark
    function automatic bit same3(board_t b, int a, int c, int d);
        return b[a] != MARK_EMPTY && b[a] == b[c] && b[c] == b[d];
    endfunction

    function automatic mark_t model_owner(board_t b);
        mark_t m;
        m = MARK_EMPTY;
        for (int k = 0; k < 3; k++)
        begin
            if (same3(b, 3 * k, 3 * k + 1, 3 * k + 2))
                m = b[3 * k];                       // row k
            if (same3(b, k, k + 3, k + 6))
                m = b[k];                           // column k
        end
        if (same3(b, 0, 4, 8) || same3(b, 2, 4, 6))
            m = b[4];                               // diagonals share the centre
        return m;
    endfunction

    function automatic bit model_over();
        bit full;
        full = 1'b1;
        for (int i = 0; i < `TTT_CELLS; i++)
        begin
            if (model_board[i] == MARK_EMPTY)
                full = 1'b0;
        end
        return full || model_owner(model_board) != MARK_EMPTY;
    endfunction

    function automatic bit model_legal(pos_t pos);
        return pos < pos_t'(`TTT_CELLS) && model_board[pos] == MARK_EMPTY;
    endfunction

    // random 0..15, forced onto a free cell after a few misses
    function automatic pos_t next_pos(int tries);
        logic [31:0] r;
        r = $urandom;
        if (tries < RANDOM_TRIES)
            return r[3:0];
        for (int i = 0; i < `TTT_CELLS; i++)
        begin
            if (model_board[i] == MARK_EMPTY)
                return pos_t'(i);
        end
        return pos_t'(0);
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        play  <= 1'b0;
        pc    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        for (int i = 0; i < `TTT_CELLS; i++)
            model_board[i] = MARK_EMPTY;
        check_board(board, model_board);
        check_winner(winner, MARK_EMPTY);
        check_flag(game_over, 1'b0, "game_over");
        check_flag(illegal_move, 1'b0, "illegal_move");
    endtask

    task automatic player_move(input pos_t pos, output bit legal);
        legal = model_legal(pos);
        @(posedge clock);
        play            <= 1'b1;
        player_position <= pos;
        @(posedge clock);   // strobe edge, position latched
        play <= 1'b0;
        @(negedge clock);   // decide cycle
        check_flag(illegal_move, !legal, "illegal_move");
        check_board(board, model_board);
        @(posedge clock);   // write edge
        @(negedge clock);
        if (legal)
            model_board[pos] = MARK_PLAYER;
        check_board(board, model_board);
        check_winner(winner, model_owner(model_board));
        check_flag(game_over, 1'b0, "game_over");
    endtask

    task automatic computer_move(input pos_t pos, output bit legal);
        legal = model_legal(pos);
        @(posedge clock);
        pc                <= 1'b1;
        computer_position <= pos;
        @(negedge clock);   // pc decided in this cycle
        check_flag(illegal_move, !legal, "illegal_move");
        @(posedge clock);   // write edge
        pc <= 1'b0;
        @(negedge clock);
        if (legal)
            model_board[pos] = MARK_COMPUTER;
        check_board(board, model_board);
        check_winner(winner, model_owner(model_board));
        check_flag(game_over, 1'b0, "game_over");
    endtask

    // strobe out of turn, nothing may change
    task automatic ignored_strobe(input bit use_play, input logic over);
        logic [31:0] r;
        r = $urandom;
        @(posedge clock);
        if (use_play)
        begin
            play            <= 1'b1;
            player_position <= r[3:0];
        end
        else
        begin
            pc                <= 1'b1;
            computer_position <= r[3:0];
        end
        @(negedge clock);
        check_flag(illegal_move, 1'b0, "illegal_move");
        @(posedge clock);
        play <= 1'b0;
        pc   <= 1'b0;
        @(negedge clock);
        check_board(board, model_board);
        check_flag(game_over, over, "game_over");
    endtask

    task automatic expect_game_end();
        turn_state_t done_state;
        done_state = TURN_DONE;
        @(posedge clock);   // one edge from idle or computer turn
        @(negedge clock);
        check_count++;
        if (game_over !== 1'b1)
        begin
            $display("game over expected but the arbiter never reached %s", done_state.name());
            error_count++;
        end
        check_winner(winner, model_owner(model_board));
        ignored_strobe(1'b1, 1'b1); // late strobes after the end
        ignored_strobe(1'b0, 1'b1);
        check_winner(winner, model_owner(model_board));
    endtask

    task automatic draw_game();
        pos_t player_seq [5];
        pos_t computer_seq [4];
        bit   ok;
        player_seq   = '{4'd0, 4'd2, 4'd5, 4'd6, 4'd7};
        computer_seq = '{4'd1, 4'd3, 4'd4, 4'd8};
        player_move(4'd12, ok);      // off the board, player tries again
        ignored_strobe(1'b0, 1'b0);  // pc while idle
        for (int i = 0; i < 5; i++)
        begin
            player_move(player_seq[i], ok);
            if (i == 0)
            begin
                ignored_strobe(1'b1, 1'b0); // play in the computer's turn
                computer_move(4'd0, ok);    // occupied, turn kept
            end
            if (i < 4)
                computer_move(computer_seq[i], ok);
        end
        expect_game_end();
        check_winner(winner, MARK_EMPTY); // full board, no line
    endtask

    task automatic random_game();
        int          tries;
        bit          ok;
        logic [31:0] r;
        while (!model_over())
        begin
            r = $urandom;
            if (r[1:0] == 2'b00)
                ignored_strobe(1'b0, 1'b0);
            tries = 0;
            do
            begin
                player_move(next_pos(tries), ok);
                tries++;
            end while (!ok);
            if (model_over())
                break;
            if (r[3:2] == 2'b00)
                ignored_strobe(1'b1, 1'b0);
            tries = 0;
            do
            begin
                computer_move(next_pos(tries), ok);
                tries++;
            end while (!ok);
        end
        expect_game_end();
    endtask

    task automatic report_test(input string name, input int errors_before);
        string result;
        case (model_owner(model_board))
            MARK_PLAYER:   result = "player wins";
            MARK_COMPUTER: result = "computer wins";
            default:       result = model_over() ? "draw" : "no game";
        endcase
        if (result == "draw")
            draw_count++;
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name, result,
                 error_count - errors_before);
    endtask

    initial
    begin : stimulus
        int seed_value;
        int errors_before;
        seed_value        = $urandom(SEED);
        reset             = 1'b1;
        play              = 1'b0;
        pc                = 1'b0;
        player_position   = '0;
        computer_position = '0;

        errors_before = error_count;
        apply_reset();
        report_test("reset", errors_before);

        errors_before = error_count;
        apply_reset();
        draw_game();
        report_test("directed draw", errors_before);

        for (int g = 0; g < NUM_GAMES; g++)
        begin
            errors_before = error_count;
            apply_reset();
            random_game();
            report_test($sformatf("random game %0d", g), errors_before);
        end

        $display("tests %0d, checks %0d, draws %0d, errors %0d",
                 test_count, check_count, draw_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/ttt_board_pkg.sv
design/ttt_turn_pkg.sv
design/board_store.sv
design/line_judge.sv
design/turn_arbiter.sv
design/tic_tac_toe_top.sv
bench/tb_tic_tac_toe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the tic-tac-toe testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f files.f --top-module tb_tic_tac_toe -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "Test failures found" "$LOG" \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
